/* regblk_pkg.sv */
package regblk_pkg;

  // Bus widths.
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Register offsets from the block base address.
  localparam addr_t CTRL_OFS   = 16'h0000;
  localparam addr_t STATUS_OFS = 16'h0004;
  localparam addr_t IRQ_OFS    = 16'h0008;
  localparam addr_t TRIG_OFS   = 16'h000C;

  // Control payload. The map places level in byte 1.
  typedef struct packed {
    logic [3:0] level;
    logic [1:0] mode;
    logic       spare;
    logic       enable;
  } ctrl_t;

  typedef logic [7:0] status_t;
  typedef logic [3:0] irq_t;
  typedef logic [3:0] trig_t;

  localparam ctrl_t CTRL_RESET = '{
    level:  4'd5,
    mode:   2'd2,
    spare:  1'b0,
    enable: 1'b0
  };

  // Read data for an access that hits no register.
  localparam data_t DEFAULT_RDATA = 32'hDEAD_BEAF;

  typedef enum logic [1:0] {
    ACC_RW,
    ACC_W1C,
    ACC_WTRIG
  } access_e;

endpackage

/* regblk_field.sv */
`timescale 1ns/1ns

module regblk_field
  import regblk_pkg::*;
#(
  parameter type     T           = logic [7:0],
  parameter access_e ACCESS      = ACC_RW,
  parameter T        RESET_VALUE = '0
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_write,
  input  T     i_wdata,
  input  T     i_wmask,
  input  T     i_hw_set,
  output T     o_value
);

  T value_q;
  T wbits;
  T clr_bits;

  // Only the strobed bits of a write take part.
  assign wbits = i_wdata & i_wmask;

  // Written ones clear interrupt bits.
  assign clr_bits = i_write ? wbits : T'('0);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      value_q <= RESET_VALUE;
    end else begin
      case (ACCESS)
        ACC_RW: begin
          if (i_write) begin
            value_q <= (value_q & ~i_wmask) | wbits;
          end
        end
        ACC_W1C: begin
          // Hardware set wins over a clear in the same cycle.
          value_q <= (value_q & ~clr_bits) | i_hw_set;
        end
        ACC_WTRIG: begin
          value_q <= i_write ? wbits : T'('0);
        end
        default: begin
          value_q <= value_q;
        end
      endcase
    end
  end

  assign o_value = value_q;

endmodule

/* regblk_apb_adapter.sv */
`timescale 1ns/1ns

module regblk_apb_adapter
  import regblk_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,

  // APB completer side.
  input  logic  i_psel,
  input  logic  i_penable,
  input  addr_t i_paddr,
  input  logic  i_pwrite,
  input  strb_t i_pstrb,
  input  data_t i_pwdata,
  output logic  o_pready,
  output data_t o_prdata,
  output logic  o_pslverr,

  // Request towards the register map.
  output logic  o_req_valid,
  output addr_t o_req_addr,
  output logic  o_req_write,
  output strb_t o_req_strb,
  output data_t o_req_wdata,

  // Response from the register map.
  input  logic  i_rsp_valid,
  input  data_t i_rsp_rdata,
  input  logic  i_rsp_err
);

  logic  setup;
  logic  req_valid_q;
  addr_t req_addr_q;
  logic  req_write_q;
  strb_t req_strb_q;
  data_t req_wdata_q;

  // Setup phase of an APB transfer.
  assign setup = i_psel & ~i_penable;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= setup;
    end
  end

  // Transfer fields are captured once per transfer.
  always_ff @(posedge clk) begin
    if (setup) begin
      req_addr_q  <= i_paddr;
      req_write_q <= i_pwrite;
      req_strb_q  <= i_pwrite ? i_pstrb : '0;
      req_wdata_q <= i_pwdata;
    end
  end

  assign o_req_valid = req_valid_q;
  assign o_req_addr  = req_addr_q;
  assign o_req_write = req_write_q;
  assign o_req_strb  = req_strb_q;
  assign o_req_wdata = req_wdata_q;

  // The response completes the transfer in the same cycle.
  assign o_pready  = i_rsp_valid;
  assign o_prdata  = i_rsp_valid ? i_rsp_rdata : '0;
  assign o_pslverr = i_rsp_valid & i_rsp_err;

endmodule

/* regblk_map.sv */
`timescale 1ns/1ns

module regblk_map
  import regblk_pkg::*;
#(
  parameter addr_t BASE_ADDR = 16'h1000
) (
  input  logic    clk,
  input  logic    i_arst_n,

  input  logic    i_req_valid,
  input  addr_t   i_req_addr,
  input  logic    i_req_write,
  input  strb_t   i_req_strb,
  input  data_t   i_req_wdata,

  output logic    o_rsp_valid,
  output data_t   o_rsp_rdata,
  output logic    o_rsp_err,

  input  status_t i_status,
  input  irq_t    i_irq_set,
  output ctrl_t   o_ctrl,
  output irq_t    o_irq,
  output trig_t   o_trigger
);

  addr_t offset;
  data_t bit_mask;
  logic  sel_ctrl;
  logic  sel_status;
  logic  sel_irq;
  logic  sel_trig;
  logic  hit;
  logic  wr_ctrl;
  logic  wr_irq;
  logic  wr_trig;
  data_t rdata_mux;
  logic  rsp_valid_q;
  data_t rsp_rdata_q;
  logic  rsp_err_q;

  // Bus word to control fields.
  function automatic ctrl_t data_to_ctrl(data_t d);
    ctrl_t c;
    c.enable = d[0];
    c.spare  = 1'b0;
    c.mode   = d[5:4];
    c.level  = d[11:8];
    return c;
  endfunction

  // Control fields to bus word, unused bits read zero.
  function automatic data_t ctrl_to_data(ctrl_t c);
    data_t d;
    d       = '0;
    d[0]    = c.enable;
    d[5:4]  = c.mode;
    d[11:8] = c.level;
    return d;
  endfunction

  assign offset = i_req_addr - BASE_ADDR;

  assign sel_ctrl   = (offset == CTRL_OFS);
  assign sel_status = (offset == STATUS_OFS);
  assign sel_irq    = (offset == IRQ_OFS);
  assign sel_trig   = (offset == TRIG_OFS);
  assign hit        = sel_ctrl | sel_status | sel_irq | sel_trig;

  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      bit_mask[i*8 +: 8] = {8{i_req_strb[i]}};
    end
  end

  assign wr_ctrl = i_req_valid & i_req_write & sel_ctrl;
  assign wr_irq  = i_req_valid & i_req_write & sel_irq;
  assign wr_trig = i_req_valid & i_req_write & sel_trig;

  regblk_field #(
    .T           (ctrl_t),
    .ACCESS      (ACC_RW),
    .RESET_VALUE (CTRL_RESET)
  ) ctrl_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_write  (wr_ctrl),
    .i_wdata  (data_to_ctrl(i_req_wdata)),
    .i_wmask  (data_to_ctrl(bit_mask)),
    .i_hw_set ('0),
    .o_value  (o_ctrl)
  );

  regblk_field #(
    .T           (irq_t),
    .ACCESS      (ACC_W1C),
    .RESET_VALUE ('0)
  ) irq_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_write  (wr_irq),
    .i_wdata  (i_req_wdata[3:0]),
    .i_wmask  (bit_mask[3:0]),
    .i_hw_set (i_irq_set),
    .o_value  (o_irq)
  );

  regblk_field #(
    .T           (trig_t),
    .ACCESS      (ACC_WTRIG),
    .RESET_VALUE ('0)
  ) trig_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_write  (wr_trig),
    .i_wdata  (i_req_wdata[3:0]),
    .i_wmask  (bit_mask[3:0]),
    .i_hw_set ('0),
    .o_value  (o_trigger)
  );

  // Trigger reads as zero.
  always_comb begin
    rdata_mux = DEFAULT_RDATA;
    if (sel_ctrl) begin
      rdata_mux = ctrl_to_data(o_ctrl);
    end else if (sel_status) begin
      rdata_mux = {{(DATA_W-8){1'b0}}, i_status};
    end else if (sel_irq) begin
      rdata_mux = {{(DATA_W-4){1'b0}}, o_irq};
    end else if (sel_trig) begin
      rdata_mux = '0;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= i_req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_req_valid) begin
      rsp_rdata_q <= i_req_write ? '0 : rdata_mux;
      rsp_err_q   <= ~hit;
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp_rdata = rsp_rdata_q;
  assign o_rsp_err   = rsp_err_q;

endmodule

/* regblk_top.sv */
`timescale 1ns/1ns

module regblk_top
  import regblk_pkg::*;
#(
  parameter addr_t BASE_ADDR = 16'h1000
) (
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_psel,
  input  logic    i_penable,
  input  addr_t   i_paddr,
  input  logic    i_pwrite,
  input  strb_t   i_pstrb,
  input  data_t   i_pwdata,
  output logic    o_pready,
  output data_t   o_prdata,
  output logic    o_pslverr,
  input  status_t i_status,
  input  irq_t    i_irq_set,
  output ctrl_t   o_ctrl,
  output irq_t    o_irq,
  output trig_t   o_trigger
);

  logic  req_valid;
  addr_t req_addr;
  logic  req_write;
  strb_t req_strb;
  data_t req_wdata;
  logic  rsp_valid;
  data_t rsp_rdata;
  logic  rsp_err;

  regblk_apb_adapter adapter_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_paddr     (i_paddr),
    .i_pwrite    (i_pwrite),
    .i_pstrb     (i_pstrb),
    .i_pwdata    (i_pwdata),
    .o_pready    (o_pready),
    .o_prdata    (o_prdata),
    .o_pslverr   (o_pslverr),
    .o_req_valid (req_valid),
    .o_req_addr  (req_addr),
    .o_req_write (req_write),
    .o_req_strb  (req_strb),
    .o_req_wdata (req_wdata),
    .i_rsp_valid (rsp_valid),
    .i_rsp_rdata (rsp_rdata),
    .i_rsp_err   (rsp_err)
  );

  regblk_map #(
    .BASE_ADDR (BASE_ADDR)
  ) map_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_req_valid (req_valid),
    .i_req_addr  (req_addr),
    .i_req_write (req_write),
    .i_req_strb  (req_strb),
    .i_req_wdata (req_wdata),
    .o_rsp_valid (rsp_valid),
    .o_rsp_rdata (rsp_rdata),
    .o_rsp_err   (rsp_err),
    .i_status    (i_status),
    .i_irq_set   (i_irq_set),
    .o_ctrl      (o_ctrl),
    .o_irq       (o_irq),
    .o_trigger   (o_trigger)
  );

endmodule

/* regblk_chk.sv */
`timescale 1ns/1ns

module regblk_chk
  import regblk_pkg::*;
(
  input logic  clk,
  input logic  i_arst_n,
  input logic  i_psel,
  input logic  i_penable,
  input logic  i_pready,
  input logic  i_pslverr,
  input trig_t i_trigger
);

  // Failed assertions so far.
  int n_fails = 0;

  // pready only in an access cycle.
  a_pready_in_access: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_pready |-> (i_psel && i_penable))
    else begin
      n_fails++;
      $error("o_pready high outside an APB access cycle");
    end

  a_pready_single: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_pready |=> !i_pready)
    else begin
      n_fails++;
      $error("o_pready high for two consecutive cycles");
    end

  a_trigger_single: assert property (@(posedge clk) disable iff (!i_arst_n)
    (|i_trigger) |=> !(|i_trigger))
    else begin
      n_fails++;
      $error("o_trigger high for two consecutive cycles");
    end

  a_slverr_with_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_pslverr |-> i_pready)
    else begin
      n_fails++;
      $error("o_pslverr high without o_pready");
    end

endmodule

bind regblk_top regblk_chk chk_i (
  .clk       (clk),
  .i_arst_n  (i_arst_n),
  .i_psel    (i_psel),
  .i_penable (i_penable),
  .i_pready  (o_pready),
  .i_pslverr (o_pslverr),
  .i_trigger (o_trigger)
);

/* tb_regblk.sv */
`timescale 1ns/1ns

module tb_regblk;
  import regblk_pkg::*;

  localparam addr_t BASE         = 16'h1000;
  localparam int    CLK_NS       = 10;
  localparam int    RESET_CYCLES = 2;
  localparam int    MAX_XFERS    = 20;
  localparam int    MAX_WAIT     = 10;
  // Four cycles per transfer with a margin of three.
  localparam int    WATCHDOG_NS  = MAX_XFERS * 4 * CLK_NS * 3 + RESET_CYCLES * CLK_NS;
  // Bits of CTRL that hold a field.
  localparam data_t CTRL_BITS    = 32'h0000_0F31;

  logic    clk;
  logic    i_arst_n;
  logic    i_psel;
  logic    i_penable;
  addr_t   i_paddr;
  logic    i_pwrite;
  strb_t   i_pstrb;
  data_t   i_pwdata;
  logic    o_pready;
  data_t   o_prdata;
  logic    o_pslverr;
  status_t i_status;
  irq_t    i_irq_set;
  ctrl_t   o_ctrl;
  irq_t    o_irq;
  trig_t   o_trigger;

  int     n_checks;
  int     n_errors;
  integer seed;
  data_t  ctrl_model;
  irq_t   irq_model;

  regblk_top #(
    .BASE_ADDR (BASE)
  ) dut_i (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_paddr   (i_paddr),
    .i_pwrite  (i_pwrite),
    .i_pstrb   (i_pstrb),
    .i_pwdata  (i_pwdata),
    .o_pready  (o_pready),
    .o_prdata  (o_prdata),
    .o_pslverr (o_pslverr),
    .i_status  (i_status),
    .i_irq_set (i_irq_set),
    .o_ctrl    (o_ctrl),
    .o_irq     (o_irq),
    .o_trigger (o_trigger)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_irq(input string name, input irq_t got, input irq_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_trig(input string name, input trig_t got, input trig_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // CTRL field layout: enable at bit 0, mode at 5:4, level at 11:8.
  function automatic ctrl_t word_to_ctrl(data_t w);
    ctrl_t c;
    c        = '0;
    c.enable = w[0];
    c.mode   = w[5:4];
    c.level  = w[11:8];
    return c;
  endfunction

  function automatic data_t strobe_mask(strb_t s);
    data_t m;
    for (int i = 0; i < STRB_W; i++) begin
      m[i*8 +: 8] = s[i] ? 8'hFF : 8'h00;
    end
    return m;
  endfunction

  // One APB transfer, optionally pulsing i_irq_set in the first access cycle.
  task automatic apb_xfer(input logic write, input addr_t addr, input strb_t strb,
                          input data_t wdata, input irq_t irq_pulse,
                          output data_t rdata, output logic err, output trig_t trig);
    int cycle;
    @(posedge clk);
    #1;
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_paddr   = addr;
    i_pwrite  = write;
    i_pstrb   = write ? strb : '0;
    i_pwdata  = wdata;
    cycle     = 1;
    @(posedge clk);
    #1;
    i_penable = 1'b1;
    i_irq_set = irq_pulse;
    cycle     = 2;
    while (o_pready !== 1'b1 && cycle < MAX_WAIT) begin
      @(posedge clk);
      #1;
      i_irq_set = '0;
      cycle++;
    end
    if (o_pready !== 1'b1) begin
      n_errors++;
      $display("o_pready did not arrive within %0d cycles at address %h", MAX_WAIT, addr);
    end else if (cycle != 3) begin
      n_errors++;
      $display("o_pready came in cycle %0d of the transfer instead of cycle 3", cycle);
    end
    rdata = o_prdata;
    err   = o_pslverr;
    trig  = o_trigger;
    @(posedge clk);
    #1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_pstrb   = '0;
    i_irq_set = '0;
  endtask

  task automatic apb_write(input addr_t addr, input strb_t strb, input data_t wdata,
                           input irq_t irq_pulse, output logic err, output trig_t trig);
    data_t unused;
    apb_xfer(1'b1, addr, strb, wdata, irq_pulse, unused, err, trig);
  endtask

  task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
    trig_t unused;
    apb_xfer(1'b0, addr, '0, '0, '0, rdata, err, unused);
  endtask

  task automatic pulse_irq(input irq_t bits);
    @(posedge clk);
    #1;
    i_irq_set = bits;
    @(posedge clk);
    #1;
    i_irq_set = '0;
    irq_model = irq_model | bits;
  endtask

  task automatic test_reset();
    data_t rdata;
    logic  err;
    check_bit("o_pready", o_pready, 1'b0);
    check_bit("o_pslverr", o_pslverr, 1'b0);
    check_data("o_prdata", o_prdata, '0);
    check_trig("o_trigger", o_trigger, '0);
    check_ctrl("o_ctrl", o_ctrl, CTRL_RESET);
    check_ctrl("o_ctrl layout", o_ctrl, word_to_ctrl(ctrl_model));
    check_irq("o_irq", o_irq, '0);
    apb_read(BASE + CTRL_OFS, rdata, err);
    check_data("CTRL read", rdata, ctrl_model);
    check_bit("CTRL read pslverr", err, 1'b0);
  endtask

  task automatic test_ctrl_rw();
    data_t wdata;
    data_t rdata;
    logic  err;
    trig_t trig;
    strb_t strb;
    wdata = $random(seed);
    strb  = 4'hF;
    apb_write(BASE + CTRL_OFS, strb, wdata, '0, err, trig);
    ctrl_model = ((ctrl_model & ~strobe_mask(strb)) | (wdata & strobe_mask(strb))) & CTRL_BITS;
    check_bit("CTRL write pslverr", err, 1'b0);
    check_ctrl("o_ctrl", o_ctrl, word_to_ctrl(ctrl_model));
    apb_read(BASE + CTRL_OFS, rdata, err);
    check_data("CTRL read", rdata, ctrl_model);
    wdata = $random(seed);
    strb  = 4'b0010;
    apb_write(BASE + CTRL_OFS, strb, wdata, '0, err, trig);
    ctrl_model = ((ctrl_model & ~strobe_mask(strb)) | (wdata & strobe_mask(strb))) & CTRL_BITS;
    check_ctrl("o_ctrl", o_ctrl, word_to_ctrl(ctrl_model));
    apb_read(BASE + CTRL_OFS, rdata, err);
    check_data("CTRL read", rdata, ctrl_model);
  endtask

  task automatic test_status();
    data_t rdata;
    logic  err;
    trig_t trig;
    i_status = 8'hA5;
    apb_read(BASE + STATUS_OFS, rdata, err);
    check_data("STATUS read", rdata, 32'h0000_00A5);
    apb_write(BASE + STATUS_OFS, 4'hF, $random(seed), '0, err, trig);
    check_bit("STATUS write pslverr", err, 1'b0);
    i_status = 8'h3C;
    apb_read(BASE + STATUS_OFS, rdata, err);
    check_data("STATUS read", rdata, 32'h0000_003C);
    check_bit("STATUS read pslverr", err, 1'b0);
  endtask

  task automatic test_irq();
    data_t rdata;
    logic  err;
    trig_t trig;
    pulse_irq(4'b1011);
    check_irq("o_irq after set", o_irq, irq_model);
    apb_write(BASE + IRQ_OFS, 4'hF, 32'h0000_0003, '0, err, trig);
    irq_model = irq_model & ~4'b0011;
    check_irq("o_irq after clear", o_irq, irq_model);
    apb_read(BASE + IRQ_OFS, rdata, err);
    check_data("IRQ read", rdata, {28'h0, irq_model});
    pulse_irq(4'b0111);
    // Bit 2 is cleared and set in the same cycle, so it stays set.
    apb_write(BASE + IRQ_OFS, 4'hF, 32'h0000_0005, 4'b0100, err, trig);
    irq_model = (irq_model & ~4'b0101) | 4'b0100;
    check_irq("o_irq after set and clear", o_irq, irq_model);
    apb_read(BASE + IRQ_OFS, rdata, err);
    check_data("IRQ read", rdata, {28'h0, irq_model});
  endtask

  task automatic test_trigger();
    data_t wdata;
    data_t rdata;
    logic  err;
    trig_t trig;
    // Bit 0 forced so that at least one trigger fires.
    wdata = $random(seed) | 32'h1;
    apb_write(BASE + TRIG_OFS, 4'hF, wdata, '0, err, trig);
    check_trig("o_trigger in pready cycle", trig, wdata[3:0]);
    check_trig("o_trigger after transfer", o_trigger, '0);
    apb_read(BASE + TRIG_OFS, rdata, err);
    check_data("TRIGGER read", rdata, '0);
  endtask

  task automatic test_unmapped();
    data_t rdata;
    logic  err;
    trig_t trig;
    apb_read(BASE + 16'h0010, rdata, err);
    check_data("unmapped read", rdata, DEFAULT_RDATA);
    check_bit("unmapped read pslverr", err, 1'b1);
    apb_write(BASE + 16'h0010, 4'hF, $random(seed), '0, err, trig);
    check_bit("unmapped write pslverr", err, 1'b1);
    check_ctrl("o_ctrl", o_ctrl, word_to_ctrl(ctrl_model));
    apb_read(BASE + CTRL_OFS, rdata, err);
    check_data("CTRL read", rdata, ctrl_model);
  endtask

  initial begin
    seed       = 57;
    n_checks   = 0;
    n_errors   = 0;
    // Enable 0, mode 2, level 5.
    ctrl_model = 32'h0000_0520;
    irq_model  = '0;
    i_arst_n   = 1'b0;
    i_psel     = 1'b0;
    i_penable  = 1'b0;
    i_paddr    = '0;
    i_pwrite   = 1'b0;
    i_pstrb    = '0;
    i_pwdata   = '0;
    i_status   = '0;
    i_irq_set  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    test_reset();
    test_ctrl_rw();
    test_status();
    test_irq();
    test_trigger();
    test_unmapped();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, dut_i.chk_i.n_fails);
    if (n_errors == 0 && dut_i.chk_i.n_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

/* sim.f */
regblk_pkg.sv
regblk_field.sv
regblk_apb_adapter.sv
regblk_map.sv
regblk_top.sv
regblk_chk.sv
tb_regblk.sv
